//--- rtl/scpad_pkg.sv
package scpad_pkg;

    // address and data widths
    localparam int DRAM_ADDR_WIDTH = 32;
    localparam int SPAD_ADDR_WIDTH = 20;
    localparam int DATA_WIDTH      = 32;

    // transfer shape
    localparam int ROW_WIDTH = 5;
    localparam int COL_WIDTH = 6;
    localparam int SUB_WIDTH = 3;

    // byte spacing, same in dram and scratchpad
    localparam int ROW_STRIDE  = 32;
    localparam int BURST_BYTES = 4;
    localparam int ROW_SHIFT   = $clog2(ROW_STRIDE);
    localparam int BURST_SHIFT = $clog2(BURST_BYTES);

    // burst count per row holds 1..8, so one bit wider than the index
    localparam int BCNT_WIDTH = SUB_WIDTH + 1;
    localparam int MAX_BURSTS = 1 << SUB_WIDTH;
    // total bursts per transfer, rows x bursts
    localparam int CNT_WIDTH  = ROW_WIDTH + SUB_WIDTH;

    // request tag layout: {engine, row, burst}
    localparam int DRAM_ID_WIDTH = 1 + ROW_WIDTH + SUB_WIDTH;
    localparam int ID_SUB_LSB    = 0;
    localparam int ID_ROW_LSB    = SUB_WIDTH;
    localparam int ID_ENG_BIT    = SUB_WIDTH + ROW_WIDTH;

    // scheduler descriptor, low address bits ignored
    typedef struct packed {
        logic                       valid;
        logic [DRAM_ADDR_WIDTH-1:0] dram_addr;
        logic [SPAD_ADDR_WIDTH-1:0] spad_addr;
        logic [ROW_WIDTH-1:0]       num_rows;
        logic [COL_WIDTH-1:0]       num_cols;
    } sched_req_t;

    // dram read request
    typedef struct packed {
        logic                       valid;
        logic [DRAM_ID_WIDTH-1:0]   id;
        logic [DRAM_ADDR_WIDTH-1:0] dram_addr;
    } dram_req_t;

    // dram read response, any order
    typedef struct packed {
        logic                     valid;
        logic [DRAM_ID_WIDTH-1:0] id;
        logic [DATA_WIDTH-1:0]    rdata;
    } dram_res_t;

    // scratchpad write port
    typedef struct packed {
        logic                       valid;
        logic [SPAD_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]      wdata;
    } sram_wr_t;

    // load engine states
    typedef enum logic [1:0] {
        BE_IDLE,
        BE_ISSUE,
        BE_DRAIN
    } be_state_e;

endpackage

//--- rtl/backend.sv
`timescale 1ns/1ns

module backend #(
    parameter logic IDX = 1'b0
) (
    input  logic                                  bshif,
    input  logic                                  arst_n,
    input  scpad_pkg::sched_req_t                 sched_req,
    output logic                                  sched_credit,
    output scpad_pkg::dram_req_t                  req,
    input  logic                                  grant,
    output logic [scpad_pkg::SPAD_ADDR_WIDTH-1:0] spad_base,
    input  logic                                  wr_done
);
    import scpad_pkg::*;

    be_state_e state;

    // latched descriptor with row aligned bases
    logic [DRAM_ADDR_WIDTH-ROW_SHIFT-1:0] dram_row_base;
    logic [SPAD_ADDR_WIDTH-ROW_SHIFT-1:0] spad_row_base;
    logic [ROW_WIDTH-1:0]                 num_rows;
    logic [BCNT_WIDTH-1:0]                num_bursts;
    logic [CNT_WIDTH-1:0]                 total;

    // issue position and completed writes
    logic [ROW_WIDTH-1:0] row;
    logic [SUB_WIDTH-1:0] sub;
    logic [CNT_WIDTH-1:0] done_cnt;

    logic [COL_WIDTH:0]             col_round;
    logic [COL_WIDTH-BURST_SHIFT:0] col_bursts;
    logic [BCNT_WIDTH-1:0]          bursts_in;
    logic                           accept;
    logic                           last_sub;
    logic                           last_row;
    logic                           last_write;

    // bursts per row from the incoming column count
    always_comb begin
        // round up to whole bursts
        col_round  = {1'b0, sched_req.num_cols} + (COL_WIDTH+1)'(BURST_BYTES - 1);
        col_bursts = col_round[COL_WIDTH:BURST_SHIFT];
        // clamp to 1..8
        if (col_bursts == '0) begin
            bursts_in = BCNT_WIDTH'(1);
        end else if (col_bursts > MAX_BURSTS) begin
            bursts_in = BCNT_WIDTH'(MAX_BURSTS);
        end else begin
            bursts_in = BCNT_WIDTH'(col_bursts);
        end
    end

    assign accept     = (state == BE_IDLE) && sched_req.valid;
    assign last_sub   = ({1'b0, sub} == num_bursts - BCNT_WIDTH'(1));
    assign last_row   = (row == num_rows - ROW_WIDTH'(1));
    assign last_write = (done_cnt == total - CNT_WIDTH'(1));

    // descriptor capture in idle only
    always_ff @(posedge bshif) begin
        if (accept) begin
            dram_row_base <= sched_req.dram_addr[DRAM_ADDR_WIDTH-1:ROW_SHIFT];
            spad_row_base <= sched_req.spad_addr[SPAD_ADDR_WIDTH-1:ROW_SHIFT];
            num_rows      <= sched_req.num_rows;
            num_bursts    <= bursts_in;
            total         <= CNT_WIDTH'(sched_req.num_rows) * CNT_WIDTH'(bursts_in);
        end
    end

    // engine fsm
    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            state        <= BE_IDLE;
            row          <= '0;
            sub          <= '0;
            done_cnt     <= '0;
            sched_credit <= 1'b0;
        end else begin
            sched_credit <= 1'b0;
            case (state)
                BE_IDLE: begin
                    if (sched_req.valid) begin
                        row      <= '0;
                        sub      <= '0;
                        done_cnt <= '0;
                        state    <= BE_ISSUE;
                    end
                end
                BE_ISSUE: begin
                    // step burst then row on each grant
                    if (grant) begin
                        if (last_sub) begin
                            sub <= '0;
                            if (last_row) begin
                                state <= BE_DRAIN;
                            end else begin
                                row <= row + ROW_WIDTH'(1);
                            end
                        end else begin
                            sub <= sub + SUB_WIDTH'(1);
                        end
                    end
                end
                BE_DRAIN: begin
                    // last write seen so hand the credit back
                    if (wr_done && last_write) begin
                        state        <= BE_IDLE;
                        sched_credit <= 1'b1;
                    end
                end
                default: begin
                    state <= BE_IDLE;
                end
            endcase
            // writes can land while still issuing
            if (wr_done && (state != BE_IDLE)) begin
                done_cnt <= done_cnt + CNT_WIDTH'(1);
            end
        end
    end

    // read request held until granted
    always_comb begin
        req.valid = (state == BE_ISSUE);
        req.id    = '0;
        req.id[ID_ENG_BIT]               = IDX;
        req.id[ID_ROW_LSB +: ROW_WIDTH]  = row;
        req.id[ID_SUB_LSB +: SUB_WIDTH]  = sub;
        // base + row stride + burst offset
        req.dram_addr = {dram_row_base, {ROW_SHIFT{1'b0}}}
                      + (DRAM_ADDR_WIDTH'(row) << ROW_SHIFT)
                      + (DRAM_ADDR_WIDTH'(sub) << BURST_SHIFT);
    end

    // aligned base for the write latch
    assign spad_base = {spad_row_base, {ROW_SHIFT{1'b0}}};

    // writes only come back for a running transfer
    a_done_busy: assert property (@(posedge bshif) disable iff (!arst_n)
        wr_done |-> state != BE_IDLE)
        else $error("backend %0d write completion while idle", IDX);

    // scheduler holds no credit while a transfer runs
    a_desc_idle: assert property (@(posedge bshif) disable iff (!arst_n)
        sched_req.valid |-> state == BE_IDLE)
        else $error("backend %0d descriptor outside idle", IDX);

endmodule

//--- rtl/dram_req_arbiter.sv
`timescale 1ns/1ns

module dram_req_arbiter #(
    parameter int CREDITS = 4
) (
    input  logic                 bshif,
    input  logic                 arst_n,
    input  scpad_pkg::dram_req_t req_0,
    input  scpad_pkg::dram_req_t req_1,
    output logic                 grant_0,
    output logic                 grant_1,
    output scpad_pkg::dram_req_t dram_req,
    input  logic                 dram_credit
);
    import scpad_pkg::*;

    localparam int CRED_WIDTH = $clog2(CREDITS + 1);

    logic [CRED_WIDTH-1:0] credit_cnt;
    // engine 1 won the last grant
    logic                  last_1;
    logic                  has_credit;
    logic                  any_grant;

    // registered bus request
    logic                       req_valid_q;
    logic [DRAM_ID_WIDTH-1:0]   id_q;
    logic [DRAM_ADDR_WIDTH-1:0] addr_q;

    assign has_credit = (credit_cnt != '0);

    // round robin gated by credit
    always_comb begin
        grant_0 = 1'b0;
        grant_1 = 1'b0;
        if (has_credit) begin
            if (req_0.valid && req_1.valid) begin
                // whoever lost last time goes now
                grant_0 = last_1;
                grant_1 = !last_1;
            end else begin
                grant_0 = req_0.valid;
                grant_1 = req_1.valid;
            end
        end
    end

    assign any_grant = grant_0 | grant_1;

    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt  <= CRED_WIDTH'(CREDITS);
            last_1      <= 1'b1;
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= any_grant;
            if (any_grant) begin
                last_1 <= grant_1;
            end
            // spend on grant and refill on credit pulse
            case ({any_grant, dram_credit})
                2'b10: begin
                    credit_cnt <= credit_cnt - CRED_WIDTH'(1);
                end
                2'b01: begin
                    // saturate at the initial pool
                    if (credit_cnt != CRED_WIDTH'(CREDITS)) begin
                        credit_cnt <= credit_cnt + CRED_WIDTH'(1);
                    end
                end
                default: begin
                    credit_cnt <= credit_cnt;
                end
            endcase
        end
    end

    // winner payload one cycle after grant
    always_ff @(posedge bshif) begin
        if (grant_0) begin
            id_q   <= req_0.id;
            addr_q <= req_0.dram_addr;
        end else if (grant_1) begin
            id_q   <= req_1.id;
            addr_q <= req_1.dram_addr;
        end
    end

    assign dram_req = '{valid: req_valid_q, id: id_q, dram_addr: addr_q};

    // engine left waiting takes the next grant
    a_turn_0: assert property (@(posedge bshif) disable iff (!arst_n)
        grant_1 && req_0.valid |=> !grant_1)
        else $error("engine 0 passed over for a second grant");

    a_turn_1: assert property (@(posedge bshif) disable iff (!arst_n)
        grant_0 && req_1.valid |=> !grant_0)
        else $error("engine 1 passed over for a second grant");

    // a returned credit needs a read outstanding
    a_credit_max: assert property (@(posedge bshif) disable iff (!arst_n)
        dram_credit |-> credit_cnt != CRED_WIDTH'(CREDITS))
        else $error("dram credit returned with the pool already full");

endmodule

//--- rtl/sram_write_latch.sv
`timescale 1ns/1ns

module sram_write_latch (
    input  logic                                  bshif,
    input  logic                                  arst_n,
    input  scpad_pkg::dram_res_t                  dram_res,
    input  logic [scpad_pkg::SPAD_ADDR_WIDTH-1:0] spad_base_0,
    input  logic [scpad_pkg::SPAD_ADDR_WIDTH-1:0] spad_base_1,
    output scpad_pkg::sram_wr_t                   sram_wr,
    output logic                                  wr_done_0,
    output logic                                  wr_done_1
);
    import scpad_pkg::*;

    // decoded response tag
    logic                 owner;
    logic [ROW_WIDTH-1:0] res_row;
    logic [SUB_WIDTH-1:0] res_sub;

    logic [SPAD_ADDR_WIDTH-1:0] owner_base;
    logic [SPAD_ADDR_WIDTH-1:0] wr_addr;

    // write stage
    logic                       wr_valid_q;
    logic [SPAD_ADDR_WIDTH-1:0] wr_addr_q;
    logic [DATA_WIDTH-1:0]      wr_data_q;

    always_comb begin
        owner   = dram_res.id[ID_ENG_BIT];
        res_row = dram_res.id[ID_ROW_LSB +: ROW_WIDTH];
        res_sub = dram_res.id[ID_SUB_LSB +: SUB_WIDTH];
        // base of whichever engine issued the read
        owner_base = owner ? spad_base_1 : spad_base_0;
        // same stride rule as the dram side
        wr_addr = owner_base
                + (SPAD_ADDR_WIDTH'(res_row) << ROW_SHIFT)
                + (SPAD_ADDR_WIDTH'(res_sub) << BURST_SHIFT);
    end

    // valid and done pulses
    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            wr_valid_q <= 1'b0;
            wr_done_0  <= 1'b0;
            wr_done_1  <= 1'b0;
        end else begin
            wr_valid_q <= dram_res.valid;
            wr_done_0  <= dram_res.valid && !owner;
            wr_done_1  <= dram_res.valid && owner;
        end
    end

    // address and data
    always_ff @(posedge bshif) begin
        if (dram_res.valid) begin
            wr_addr_q <= wr_addr;
            wr_data_q <= dram_res.rdata;
        end
    end

    assign sram_wr = '{valid: wr_valid_q, addr: wr_addr_q, wdata: wr_data_q};

endmodule

//--- rtl/scpad_backend_top.sv
`timescale 1ns/1ns

module scpad_backend_top #(
    parameter int DRAM_CREDITS = 4
) (
    input  logic                  bshif,
    input  logic                  arst_n,
    input  scpad_pkg::sched_req_t sched_req_0,
    input  scpad_pkg::sched_req_t sched_req_1,
    output logic                  sched_credit_0,
    output logic                  sched_credit_1,
    output scpad_pkg::dram_req_t  dram_req,
    input  logic                  dram_credit,
    input  scpad_pkg::dram_res_t  dram_res,
    output scpad_pkg::sram_wr_t   sram_wr
);
    import scpad_pkg::*;

    // engine to arbiter
    dram_req_t req_0;
    dram_req_t req_1;
    logic      grant_0;
    logic      grant_1;

    // engine to write latch
    logic [SPAD_ADDR_WIDTH-1:0] spad_base_0;
    logic [SPAD_ADDR_WIDTH-1:0] spad_base_1;
    logic                       wr_done_0;
    logic                       wr_done_1;

    backend #(.IDX(1'b0)) u_backend_0 (
        .bshif        (bshif),
        .arst_n       (arst_n),
        .sched_req    (sched_req_0),
        .sched_credit (sched_credit_0),
        .req          (req_0),
        .grant        (grant_0),
        .spad_base    (spad_base_0),
        .wr_done      (wr_done_0)
    );

    backend #(.IDX(1'b1)) u_backend_1 (
        .bshif        (bshif),
        .arst_n       (arst_n),
        .sched_req    (sched_req_1),
        .sched_credit (sched_credit_1),
        .req          (req_1),
        .grant        (grant_1),
        .spad_base    (spad_base_1),
        .wr_done      (wr_done_1)
    );

    // shared dram request bus
    dram_req_arbiter #(.CREDITS(DRAM_CREDITS)) u_arbiter (
        .bshif       (bshif),
        .arst_n      (arst_n),
        .req_0       (req_0),
        .req_1       (req_1),
        .grant_0     (grant_0),
        .grant_1     (grant_1),
        .dram_req    (dram_req),
        .dram_credit (dram_credit)
    );

    // responses back into the scratchpad
    sram_write_latch u_write_latch (
        .bshif       (bshif),
        .arst_n      (arst_n),
        .dram_res    (dram_res),
        .spad_base_0 (spad_base_0),
        .spad_base_1 (spad_base_1),
        .sram_wr     (sram_wr),
        .wr_done_0   (wr_done_0),
        .wr_done_1   (wr_done_1)
    );

endmodule

//--- test/tb_scpad_backend.sv
`timescale 1ns/1ns

module tb_scpad_backend;
    import scpad_pkg::*;

    localparam int DRAM_CREDITS = 4;
    localparam int NUM_XFERS    = 8;
    localparam int HOLD_CYCLES  = 30;
    localparam int SEED         = 3228;
    localparam logic [DATA_WIDTH-1:0] DATA_XOR = 32'h5a3c_c3a5;

    // one table row per transfer
    typedef struct packed {
        logic                       eng;
        logic [DRAM_ADDR_WIDTH-1:0] dram_addr;
        logic [SPAD_ADDR_WIDTH-1:0] spad_addr;
        logic [ROW_WIDTH-1:0]       rows;
        logic [COL_WIDTH-1:0]       cols;
        logic                       with_next;
        logic                       hold;
    } xfer_t;

    // with_next launches this row and the next in the same cycle
    // hold keeps the responder silent until the credits run dry
    xfer_t xfers [NUM_XFERS] = '{
        // eng  dram base      spad base   rows  cols   next  hold
        '{1'b0, 32'h0000_1000, 20'h00400, 5'd3, 6'd1,  1'b1, 1'b0},
        '{1'b1, 32'h0002_0040, 20'h08020, 5'd4, 6'd32, 1'b0, 1'b0},
        '{1'b0, 32'h0010_0000, 20'h01000, 5'd2, 6'd5,  1'b0, 1'b0},
        '{1'b1, 32'h0003_00e0, 20'h0a0c0, 5'd2, 6'd4,  1'b0, 1'b0},
        '{1'b0, 32'h1234_5660, 20'h03300, 5'd5, 6'd12, 1'b1, 1'b0},
        '{1'b1, 32'h0000_8000, 20'h0c000, 5'd3, 6'd17, 1'b0, 1'b0},
        '{1'b1, 32'h00ab_cd1f, 20'h0f0f5, 5'd2, 6'd30, 1'b0, 1'b1},
        '{1'b0, 32'h0000_0000, 20'h00000, 5'd1, 6'd8,  1'b0, 1'b0}
    };

    logic       bshif;
    logic       arst_n;
    sched_req_t sched_req_0;
    sched_req_t sched_req_1;
    logic       sched_credit_0;
    logic       sched_credit_1;
    dram_req_t  dram_req;
    logic       dram_credit;
    dram_res_t  dram_res;
    sram_wr_t   sram_wr;

    // expected traffic per engine in issue order
    dram_req_t exp_req_0 [$];
    dram_req_t exp_req_1 [$];
    sram_wr_t  exp_wrq_0 [$];
    sram_wr_t  exp_wrq_1 [$];
    // reads on the bus not yet answered
    dram_req_t pending_req [$];
    sram_wr_t  pending_wr [$];
    // writes due in answer order
    sram_wr_t  exp_wr [$];
    logic      exp_wr_eng [$];

    logic [1:0] busy;
    logic       hold_resp;
    int         writes_left [2];
    int         writes_seen;
    int         credits_seen;
    logic       last_eng;
    int         run_len;

    scpad_backend_top #(.DRAM_CREDITS(DRAM_CREDITS)) DUT (
        .bshif          (bshif),
        .arst_n         (arst_n),
        .sched_req_0    (sched_req_0),
        .sched_req_1    (sched_req_1),
        .sched_credit_0 (sched_credit_0),
        .sched_credit_1 (sched_credit_1),
        .dram_req       (dram_req),
        .dram_credit    (dram_credit),
        .dram_res       (dram_res),
        .sram_wr        (sram_wr)
    );

    always #10 bshif = ~bshif;

    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_dram_req(input string name, input dram_req_t got, input dram_req_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_sram_wr(input string name, input sram_wr_t got, input sram_wr_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    // ceil(cols / 4) kept within 1..8
    function automatic int bursts_for(input logic [COL_WIDTH-1:0] cols);
        int n;
        n = (int'(cols) + BURST_BYTES - 1) / BURST_BYTES;
        if (n < 1) begin
            n = 1;
        end else if (n > MAX_BURSTS) begin
            n = MAX_BURSTS;
        end
        return n;
    endfunction

    function automatic int total_requests();
        int sum;
        sum = 0;
        foreach (xfers[k]) begin
            sum = sum + int'(xfers[k].rows) * bursts_for(xfers[k].cols);
        end
        return sum;
    endfunction

    // present a descriptor and queue its expected reads and writes
    task automatic launch(input xfer_t x);
        sched_req_t                 d;
        dram_req_t                  r;
        sram_wr_t                   w;
        int                         nb;
        int                         row;
        int                         b;
        logic [DRAM_ADDR_WIDTH-1:0] dbase;
        logic [SPAD_ADDR_WIDTH-1:0] sbase;
        d = '{valid: 1'b1, dram_addr: x.dram_addr, spad_addr: x.spad_addr,
              num_rows: x.rows, num_cols: x.cols};
        nb = bursts_for(x.cols);
        // low five address bits dropped
        dbase = x.dram_addr & ~DRAM_ADDR_WIDTH'(ROW_STRIDE - 1);
        sbase = x.spad_addr & ~SPAD_ADDR_WIDTH'(ROW_STRIDE - 1);
        for (row = 0; row < int'(x.rows); row++) begin
            for (b = 0; b < nb; b++) begin
                r.valid     = 1'b1;
                r.id        = {x.eng, ROW_WIDTH'(row), SUB_WIDTH'(b)};
                r.dram_addr = dbase + DRAM_ADDR_WIDTH'(row * ROW_STRIDE + b * BURST_BYTES);
                w.valid     = 1'b1;
                w.addr      = sbase + SPAD_ADDR_WIDTH'(row * ROW_STRIDE + b * BURST_BYTES);
                // responder returns address xor pattern
                w.wdata     = r.dram_addr ^ DATA_XOR;
                if (x.eng) begin
                    exp_req_1.push_back(r);
                    exp_wrq_1.push_back(w);
                end else begin
                    exp_req_0.push_back(r);
                    exp_wrq_0.push_back(w);
                end
            end
        end
        busy[x.eng]       <= 1'b1;
        writes_left[x.eng] = int'(x.rows) * nb;
        if (x.eng) begin
            sched_req_1 = d;
        end else begin
            sched_req_0 = d;
        end
    endtask

    // bus monitor and dram responder on the falling edge
    always @(negedge bshif) begin : monitor
        dram_req_t  r;
        sram_wr_t   w;
        int         idx;
        int         e;
        int         other_left;
        logic       eng;
        logic [1:0] credit_bits;
        if (arst_n) begin
            if (sram_wr.valid) begin
                if (exp_wr.size() == 0) begin
                    $display("scratchpad write at %0t with no answer outstanding", $time);
                    fail_run();
                end else begin
                    check_sram_wr("sram_wr", sram_wr, exp_wr.pop_front());
                    eng = exp_wr_eng.pop_front();
                    writes_left[eng] = writes_left[eng] - 1;
                    writes_seen++;
                end
            end
            // one credit per transfer once all its writes landed
            credit_bits = {sched_credit_1, sched_credit_0};
            for (e = 0; e < 2; e++) begin
                if (credit_bits[e]) begin
                    if (!busy[e] || writes_left[e] != 0) begin
                        $display("engine %0d returned a scheduler credit early at %0t", e, $time);
                        fail_run();
                    end
                    busy[e] <= 1'b0;
                    credits_seen++;
                end
            end
            if (dram_req.valid) begin
                eng = dram_req.id[ID_ENG_BIT];
                if ((eng && exp_req_1.size() == 0) || (!eng && exp_req_0.size() == 0)) begin
                    $display("read at %0t from engine %0d with nothing left to issue", $time, eng);
                    fail_run();
                end else if (eng) begin
                    r = exp_req_1.pop_front();
                    w = exp_wrq_1.pop_front();
                end else begin
                    r = exp_req_0.pop_front();
                    w = exp_wrq_0.pop_front();
                end
                check_dram_req("dram_req", dram_req, r);
                pending_req.push_back(dram_req);
                pending_wr.push_back(w);
                if (pending_req.size() > DRAM_CREDITS) begin
                    $display("more reads outstanding than dram credits at %0t", $time);
                    fail_run();
                end
                // same engine again while the other still has work
                other_left = eng ? exp_req_0.size() : exp_req_1.size();
                if (other_left == 0) begin
                    run_len = 0;
                end else if (eng == last_eng) begin
                    run_len++;
                end else begin
                    run_len = 1;
                end
                last_eng = eng;
                if (run_len > 3) begin
                    $display("engine %0d starved of grants at %0t", !eng, $time);
                    fail_run();
                end
            end
            // answer a random outstanding read rather than the oldest
            if (!hold_resp && pending_req.size() > 0 && $urandom_range(0, 2) != 0) begin
                idx = int'($urandom_range(0, pending_req.size() - 1));
                r = pending_req[idx];
                dram_res    = '{valid: 1'b1, id: r.id, rdata: r.dram_addr ^ DATA_XOR};
                dram_credit = 1'b1;
                exp_wr.push_back(pending_wr[idx]);
                exp_wr_eng.push_back(r.id[ID_ENG_BIT]);
                pending_req.delete(idx);
                pending_wr.delete(idx);
            end else begin
                dram_res    = '0;
                dram_credit = 1'b0;
            end
        end
    end

    // watchdog
    initial begin : watchdog
        int limit;
        limit = total_requests() * 40 + 1000;
        repeat (limit) @(posedge bshif);
        $display("timeout, run still going after %0d cycles", limit);
        fail_run();
    end

    initial begin : stimulus
        int i;
        bshif        = 1'b0;
        arst_n       = 1'b0;
        sched_req_0  = '0;
        sched_req_1  = '0;
        dram_credit  = 1'b0;
        dram_res     = '0;
        busy        <= '0;
        hold_resp   <= 1'b0;
        writes_left  = '{0, 0};
        writes_seen  = 0;
        credits_seen = 0;
        last_eng     = 1'b0;
        run_len      = 0;
        void'($urandom(SEED));
        repeat (3) @(posedge bshif);
        @(negedge bshif);
        arst_n = 1'b1;
        check_flag("dram_req.valid", dram_req.valid, 1'b0);
        check_flag("sram_wr.valid", sram_wr.valid, 1'b0);
        check_flag("sched_credit_0", sched_credit_0, 1'b0);
        check_flag("sched_credit_1", sched_credit_1, 1'b0);
        i = 0;
        while (i < NUM_XFERS) begin
            if (xfers[i].hold) begin
                // drain first so the whole pool is in use
                while (busy != 2'b00) @(negedge bshif);
                hold_resp <= 1'b1;
            end
            if (xfers[i].with_next) begin
                while (busy != 2'b00) @(negedge bshif);
                launch(xfers[i]);
                launch(xfers[i + 1]);
                i = i + 2;
            end else begin
                while (busy[xfers[i].eng]) @(negedge bshif);
                launch(xfers[i]);
                i = i + 1;
            end
            // valid for one cycle only
            @(negedge bshif);
            sched_req_0 = '0;
            sched_req_1 = '0;
            if (hold_resp) begin
                repeat (HOLD_CYCLES) @(negedge bshif);
                if (pending_req.size() != DRAM_CREDITS) begin
                    $display("with credits held, %0d reads outstanding instead of %0d",
                             pending_req.size(), DRAM_CREDITS);
                    fail_run();
                end
                hold_resp <= 1'b0;
            end
        end
        while (busy != 2'b00) @(negedge bshif);
        // quiet stretch where stray writes or credits would show up
        repeat (20) @(negedge bshif);
        if (writes_seen != total_requests() || credits_seen != NUM_XFERS ||
            pending_req.size() != 0 || exp_wr.size() != 0) begin
            $display("run ended with %0d of %0d writes and %0d of %0d scheduler credits",
                     writes_seen, total_requests(), credits_seen, NUM_XFERS);
            fail_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- sources.f
rtl/scpad_pkg.sv
rtl/backend.sv
rtl/dram_req_arbiter.sv
rtl/sram_write_latch.sv
rtl/scpad_backend_top.sv
test/tb_scpad_backend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_scpad_backend
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
